// File: common/disp_pkg.sv
`default_nettype none

package disp_pkg;

    // ----------------------------------------
    // image geometry
    // ----------------------------------------
    localparam int img_w = 8;
    localparam int img_h = 8;
    localparam int img_c = 32;                     // max channel count
    localparam int img_pix = img_w * img_h * img_c; // 2048 pixels

    // banked storage, channel low bits pick the bank
    localparam int bank_cnt = 4;
    localparam int bank_bits = 2;
    localparam int bank_depth = img_pix / bank_cnt; // 512 words each

    localparam logic [2:0] org_max = 3'd6;         // keeps 2x2 window inside

    // depth codes
    localparam logic [1:0] depth_8 = 2'd0;
    localparam logic [1:0] depth_16 = 2'd1;
    localparam logic [1:0] depth_32 = 2'd2;        // reset value

    // ----------------------------------------
    // opcodes
    // ----------------------------------------
    localparam logic [3:0] op_load = 4'd0;
    localparam logic [3:0] op_org_r = 4'd1;
    localparam logic [3:0] op_org_l = 4'd2;
    localparam logic [3:0] op_org_u = 4'd3;
    localparam logic [3:0] op_org_d = 4'd4;
    localparam logic [3:0] op_scale_d = 4'd5;
    localparam logic [3:0] op_scale_u = 4'd6;
    localparam logic [3:0] op_display = 4'd7;

    // controller FSM encoding
    localparam logic [3:0] st_reset = 4'd0;
    localparam logic [3:0] st_start = 4'd1;
    localparam logic [3:0] st_ready = 4'd2;        // op_ready pulse
    localparam logic [3:0] st_wait = 4'd3;
    localparam logic [3:0] st_load = 4'd4;
    localparam logic [3:0] st_org_r = 4'd5;
    localparam logic [3:0] st_org_l = 4'd6;
    localparam logic [3:0] st_org_u = 4'd7;
    localparam logic [3:0] st_org_d = 4'd8;
    localparam logic [3:0] st_scale_d = 4'd9;
    localparam logic [3:0] st_scale_u = 4'd10;
    localparam logic [3:0] st_display = 4'd11;

    typedef logic [7:0] pix_t;                     // unsigned pixel

    // one pixel address, two readings of the same 11 bits
    typedef union packed {
        struct packed {
            logic [4:0] ch;
            logic [2:0] y;
            logic [2:0] x;
        } img;                                     // raster view, channel-major
        struct packed {
            logic [2:0] ch_hi;                     // channel bits 4..2
            logic [1:0] bank;                      // channel bits 1..0
            logic [5:0] idx;                       // y*8 + x
        } mem;                                     // storage view
    } pix_addr_t;

    // last channel index for a depth code
    function automatic logic [4:0] depth_last(input logic [1:0] depth);
        case (depth)
            depth_8: return 5'd7;
            depth_16: return 5'd15;
            default: return 5'd31;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: common/img_mem_if.sv
`default_nettype none

// request / return path between controller, banks and output stage
interface img_mem_if
    import disp_pkg::*;
();

    logic      wr_en;    // single-cycle write strobe
    logic      rd_en;    // single-cycle read strobe, never with wr_en
    pix_addr_t addr;     // image view written, memory view read
    pix_t      wdata;
    pix_t      rdata;    // valid with rvalid
    logic      rvalid;   // rd_en delayed by one cycle

    // controller side, rvalid only for drain detect
    modport ctl (
        output wr_en,
        output rd_en,
        output addr,
        output wdata,
        input  rvalid
    );

    // bank side
    modport mem (
        input  wr_en,
        input  rd_en,
        input  addr,
        input  wdata,
        output rdata,
        output rvalid
    );

    modport snk (input rdata, input rvalid);  // output streamer

endinterface

`default_nettype wire

// File: src/cmd_ctrl.sv
`default_nettype none

module cmd_ctrl
    import disp_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_op_valid,
    input  wire  [3:0] i_op_mode,
    input  wire        i_in_valid,
    input  wire  pix_t i_in_data,
    output logic       o_op_ready,
    output logic       o_in_ready,
    img_mem_if.ctl     mem
);

    // ----------------------------------------
    // registered inputs
    // ----------------------------------------
    logic       op_valid_r;
    logic [3:0] op_mode_r;
    logic       in_take_r;   // pixel accepted last edge, write it now
    pix_t       in_data_r;

    logic [3:0] state;
    logic [3:0] state_nx;

    logic [2:0] org_x;       // window origin, 0..org_max
    logic [2:0] org_y;
    logic [1:0] depth;       // depth code

    logic [10:0] load_cnt;   // pixels written so far
    logic        load_full;  // 2048th pixel taken, stop accepting
    logic        last_take;

    logic [1:0] disp_pos;    // 0:(x,y) 1:(x+1,y) 2:(x,y+1) 3:(x+1,y+1)
    logic [4:0] disp_c;      // channel being read
    logic       disp_drain;  // all reads issued, wait for rvalid to fall

    assign o_op_ready = (state == st_ready);
    assign o_in_ready = (state == st_load) && !load_full;

    // accepted count = written + pending write
    assign last_take = o_in_ready && i_in_valid
                    && (({1'b0, load_cnt} + 12'(in_take_r)) == 12'(img_pix - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            op_valid_r <= 1'b0;
            op_mode_r  <= 4'd0;
            in_take_r  <= 1'b0;
        end else begin
            op_valid_r <= i_op_valid;
            op_mode_r  <= i_op_mode;
            in_take_r  <= i_in_valid && o_in_ready; // only handshaked pixels
        end
    end

    always_ff @(posedge i_clk) begin
        in_data_r <= i_in_data;
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_nx = state;
        case (state)
            st_reset: state_nx = st_start;
            st_start: state_nx = st_ready;
            st_ready: state_nx = st_wait;
            st_wait: begin
                if (op_valid_r) begin
                    case (op_mode_r)
                        op_load:    state_nx = st_load;
                        op_org_r:   state_nx = st_org_r;
                        op_org_l:   state_nx = st_org_l;
                        op_org_u:   state_nx = st_org_u;
                        op_org_d:   state_nx = st_org_d;
                        op_scale_d: state_nx = st_scale_d;
                        op_scale_u: state_nx = st_scale_u;
                        op_display: state_nx = st_display;
                        default:    state_nx = st_wait;   // undefined, ignored
                    endcase
                end
            end
            st_load: begin
                if (in_take_r && (load_cnt == 11'(img_pix - 1))) state_nx = st_ready;
            end
            st_org_r, st_org_l, st_org_u, st_org_d, st_scale_d, st_scale_u: begin
                state_nx = st_ready;                      // one-cycle update
            end
            st_display: begin
                if (disp_drain && !mem.rvalid) state_nx = st_ready;
            end
            default: state_nx = st_wait;
        endcase
    end

    // ----------------------------------------
    // state, origin, depth and counters
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= st_reset;
            org_x      <= 3'd0;
            org_y      <= 3'd0;
            depth      <= depth_32;
            load_cnt   <= 11'd0;
            load_full  <= 1'b0;
            disp_pos   <= 2'd0;
            disp_c     <= 5'd0;
            disp_drain <= 1'b0;
        end else begin
            state <= state_nx;
            case (state)
                st_ready: load_full <= 1'b0;
                st_load: begin
                    if (last_take) load_full <= 1'b1;
                    if (in_take_r) load_cnt <= load_cnt + 11'd1; // wraps to 0 at end
                end
                // saturating origin moves
                st_org_r: if (org_x < org_max) org_x <= org_x + 3'd1;
                st_org_l: if (org_x != 3'd0) org_x <= org_x - 3'd1;
                st_org_u: if (org_y != 3'd0) org_y <= org_y - 3'd1;
                st_org_d: if (org_y < org_max) org_y <= org_y + 3'd1;
                // saturating depth steps
                st_scale_d: if (depth != depth_8) depth <= depth - 2'd1;
                st_scale_u: if (depth != depth_32) depth <= depth + 2'd1;
                st_display: begin
                    if (!disp_drain) begin
                        disp_pos <= disp_pos + 2'd1;
                        if (disp_pos == 2'd3) begin
                            if (disp_c == depth_last(depth)) begin
                                disp_c     <= 5'd0;
                                disp_drain <= 1'b1;       // last read issued
                            end else begin
                                disp_c <= disp_c + 5'd1;
                            end
                        end
                    end else if (!mem.rvalid) begin
                        disp_drain <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // memory requests, image view addressing
    // ----------------------------------------
    always_comb begin
        mem.wr_en = 1'b0;
        mem.rd_en = 1'b0;
        mem.addr  = '0;
        mem.wdata = in_data_r;
        if (state == st_load) begin
            mem.wr_en    = in_take_r;
            mem.addr.img = load_cnt;                  // raster order is c,y,x
        end else if (state == st_display) begin
            mem.rd_en      = !disp_drain;             // one read per cycle
            mem.addr.img.ch = disp_c;
            mem.addr.img.y  = org_y + {2'b00, disp_pos[1]};
            mem.addr.img.x  = org_x + {2'b00, disp_pos[0]};
        end
    end

endmodule

`default_nettype wire

// File: image_mem/image_mem.sv
`default_nettype none

module image_mem
    import disp_pkg::*;
(
    input  wire     i_clk,
    img_mem_if.mem  mem
);

    localparam int off_w = $clog2(bank_depth);   // 9 bit word offset

    // ----------------------------------------
    // address decode, memory view
    // ----------------------------------------
    logic [bank_bits-1:0] bank_sel;
    logic [off_w-1:0]     bank_off;

    assign bank_sel = mem.addr.mem.bank;                          // channel low bits
    assign bank_off = {mem.addr.mem.ch_hi, mem.addr.mem.idx};     // ch_hi*64 + pixel

    pix_t bank_rd [bank_cnt];   // raw word of each bank at bank_off
    pix_t rdata_q;
    logic rvalid_q;

    // ----------------------------------------
    // four pixel banks
    // ----------------------------------------
    for (genvar b = 0; b < bank_cnt; b++) begin : g_bank
        pix_t ram [bank_depth];

        always_ff @(posedge i_clk) begin
            if (mem.wr_en && (bank_sel == bank_bits'(b))) begin
                ram[bank_off] <= mem.wdata;       // only the addressed bank
            end
        end

        assign bank_rd[b] = ram[bank_off];
    end

    // read port, one cycle latency
    always_ff @(posedge i_clk) begin
        rvalid_q <= mem.rd_en;
        if (mem.rd_en) begin
            rdata_q <= bank_rd[bank_sel];         // hold between reads
        end
    end

    assign mem.rdata  = rdata_q;
    assign mem.rvalid = rvalid_q;

endmodule

`default_nettype wire

// File: src/out_stream.sv
`default_nettype none

module out_stream
    import disp_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    img_mem_if.snk      snk,
    output logic        o_out_valid,
    output logic [13:0] o_out_data
);

    // pad width for zero extension of a pixel
    localparam int pad_w = 14 - $bits(pix_t);

    // ----------------------------------------
    // output register stage
    // ----------------------------------------
    // valid follows the memory return by one cycle,
    // data only loads on a return and keeps the last pixel
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
            o_out_data  <= 14'd0;
        end else begin
            o_out_valid <= snk.rvalid;
            if (snk.rvalid) begin
                o_out_data <= {{pad_w{1'b0}}, snk.rdata}; // unsigned pixel
            end
        end
    end

endmodule

`default_nettype wire

// File: src/img_disp_top.sv
`default_nettype none

module img_disp_top
    import disp_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,       // async, active low
    input  wire         i_op_valid,    // opcode strobe
    input  wire   [3:0] i_op_mode,
    input  wire         i_in_valid,    // pixel strobe during load
    input  wire   pix_t i_in_data,
    output logic        o_op_ready,    // one pulse per finished op
    output logic        o_in_ready,
    output logic        o_out_valid,   // display stream, no back-pressure
    output logic [13:0] o_out_data
);

    // ----------------------------------------
    // memory bus shared by all three blocks
    // ----------------------------------------
    img_mem_if u_bus ();

    // command decode, origin/depth state, request generation
    cmd_ctrl u_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op_valid (i_op_valid),
        .i_op_mode  (i_op_mode),
        .i_in_valid (i_in_valid),
        .i_in_data  (i_in_data),
        .o_op_ready (o_op_ready),
        .o_in_ready (o_in_ready),
        .mem        (u_bus.ctl)
    );

    // banked pixel storage
    image_mem u_mem (
        .i_clk (i_clk),
        .mem   (u_bus.mem)
    );

    // read returns onto the output pins
    out_stream u_out (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .snk         (u_bus.snk),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

endmodule

`default_nettype wire

// File: tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------
// error exit
// ----------------------------------------
task automatic abort_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
endtask

// 14 bit display data
task automatic check_pix(input logic [13:0] got, input logic [13:0] exp, input string msg);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t: %s got 0x%0h expected 0x%0h",
                            $time, msg, got, exp));
    end
endtask

// ready / valid levels
task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] %0t: %s got %b expected %b", $time, msg, got, exp));
    end
endtask

// ----------------------------------------
// waits, all bounded
// ----------------------------------------
task automatic wait_ready(input int limit, input string what);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && (n < limit)) begin
        @(negedge i_clk);
        n++;
        seen = o_op_ready;                // returns on the pulse edge
    end
    if (!seen) begin
        abort_run($sformatf("timeout: no o_op_ready pulse after %s within %0d cycles",
                            what, limit));
    end
endtask

// checks one contiguous o_out_valid run against exp_q
task automatic collect_stream(input int limit);
    int   n;
    int   k;
    int   wait_n;
    logic seen;
    n      = exp_q.size();
    wait_n = 0;
    seen   = 1'b0;
    while (!seen && (wait_n < limit)) begin
        @(negedge i_clk);
        wait_n++;
        seen = o_out_valid;
    end
    if (!seen) begin
        abort_run("timeout: display stream never started, o_out_valid stayed low");
    end
    for (k = 0; k < n; k++) begin
        if (k > 0) @(negedge i_clk);      // no back-pressure, one per cycle
        check_bit(o_out_valid, 1'b1, $sformatf("o_out_valid at stream value %0d", k));
        check_pix(o_out_data, exp_q.pop_front(), $sformatf("stream value %0d", k));
    end
endtask

`endif

// File: tests/tb_img_disp.sv
`default_nettype none

module tb_img_disp
    import disp_pkg::*;
();

    localparam logic [31:0] lfsr_seed = 32'd84404;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;  // x^32+x^22+x^2+x+1
    localparam int simple_limit = 4;     // origin/scale pulse window
    localparam int load_limit = 20000;   // gapped load of 2048 pixels
    localparam int disp_limit = 200;

    logic        i_clk = 1'b0;
    logic        i_rst_n;
    logic        i_op_valid;
    logic  [3:0] i_op_mode;
    logic        i_in_valid;
    pix_t        i_in_data;
    logic        o_op_ready;
    logic        o_in_ready;
    logic        o_out_valid;
    logic [13:0] o_out_data;

    logic [31:0] lfsr_state;
    pix_t        img_model [img_pix];   // raster order c,y,x
    logic [13:0] exp_q [$];            // expected display values
    int          m_ox;
    int          m_oy;
    int          m_depth;               // active channels 8/16/32

    `include "tb_checks.svh"

    always #5 i_clk = ~i_clk;

    img_disp_top u_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (i_op_mode),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .o_op_ready  (o_op_ready),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    // galois lfsr, one step per bit taken
    function automatic logic rand_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ lfsr_taps;
        return out;
    endfunction

    // one-cycle opcode strobe, starts on the current falling edge
    task automatic send_op(input logic [3:0] mode);
        i_op_valid = 1'b1;
        i_op_mode  = mode;
        @(negedge i_clk);
        i_op_valid = 1'b0;
    endtask

    // origin or scale opcode plus model update
    task automatic run_simple_op(input logic [3:0] mode);
        send_op(mode);
        wait_ready(simple_limit, "origin/scale opcode");
        case (mode)
            op_org_r:   if (m_ox < int'(org_max)) m_ox++;
            op_org_l:   if (m_ox > 0) m_ox--;
            op_org_u:   if (m_oy > 0) m_oy--;
            op_org_d:   if (m_oy < int'(org_max)) m_oy++;
            op_scale_d: if (m_depth > 8) m_depth = m_depth / 2;
            op_scale_u: if (m_depth < 32) m_depth = m_depth * 2;
            default: ;
        endcase
    endtask

    // window order per channel: (x,y) (x+1,y) (x,y+1) (x+1,y+1)
    task automatic build_expected();
        int c;
        int p;
        int x;
        int y;
        exp_q.delete();
        for (c = 0; c < m_depth; c++) begin
            for (p = 0; p < 4; p++) begin
                x = m_ox + (p % 2);
                y = m_oy + (p / 2);
                exp_q.push_back({6'd0, img_model[c * img_w * img_h + y * img_w + x]});
            end
        end
    endtask

    task automatic display_and_check();
        build_expected();
        send_op(op_display);
        collect_stream(disp_limit);
        wait_ready(8, "end of DISPLAY stream");
        check_bit(o_out_valid, 1'b0, "o_out_valid after stream end");
    endtask

    // gapped load, only handshaked pixels advance
    task automatic load_image();
        int   idx;
        int   cycles;
        logic take;
        idx    = 0;
        cycles = 0;
        send_op(op_load);
        while (idx < img_pix) begin
            if (cycles >= load_limit) begin
                abort_run($sformatf("timeout: LOAD accepted only %0d pixels", idx));
            end
            @(negedge i_clk);
            cycles++;
            take       = rand_bit();
            i_in_valid = take;
            i_in_data  = img_model[idx];
            if (take && o_in_ready) idx++;   // o_in_ready stable until next rise
        end
        @(negedge i_clk);
        i_in_valid = 1'b0;
        check_bit(o_in_ready, 1'b0, "o_in_ready after last pixel");
        wait_ready(8, "LOAD");
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic reset_test();
        repeat (5) begin
            @(negedge i_clk);
            check_bit(o_in_ready, 1'b0, "o_in_ready in reset");
            check_bit(o_out_valid, 1'b0, "o_out_valid in reset");
            check_pix(o_out_data, 14'd0, "o_out_data in reset");
        end
        i_rst_n = 1'b1;
        wait_ready(10, "reset release");
        check_bit(o_in_ready, 1'b0, "o_in_ready after reset");
        check_bit(o_out_valid, 1'b0, "o_out_valid after reset");
        check_pix(o_out_data, 14'd0, "o_out_data after reset");
        @(negedge i_clk);
        check_bit(o_op_ready, 1'b0, "o_op_ready pulse width");   // single pulse
    endtask

    task automatic load_display_test();
        load_image();
        display_and_check();      // origin (0,0), depth 32
    endtask

    task automatic origin_test();
        repeat (8) run_simple_op(op_org_r);
        repeat (8) run_simple_op(op_org_d);
        run_simple_op(op_org_l);
        run_simple_op(op_org_u);
        display_and_check();      // window at (5,5)
    endtask

    task automatic scale_test();
        repeat (3) run_simple_op(op_scale_d);
        display_and_check();      // 8 channels, 32 values
        run_simple_op(op_scale_u);
        display_and_check();      // 16 channels, 64 values
    endtask

    task automatic undefined_test();
        logic [3:0] bad_ops [3];
        int         i;
        bad_ops = '{4'd8, 4'd9, 4'd15};
        for (i = 0; i < 3; i++) begin
            send_op(bad_ops[i]);
            repeat (20) begin
                @(negedge i_clk);
                check_bit(o_op_ready, 1'b0, $sformatf("o_op_ready for opcode %0d", bad_ops[i]));
            end
        end
        display_and_check();
    endtask

    initial begin
        pix_t p;
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = 4'd0;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        lfsr_state = lfsr_seed;
        m_ox       = 0;
        m_oy       = 0;
        m_depth    = 32;
        // model image, 8 lfsr bits per pixel
        for (int i = 0; i < img_pix; i++) begin
            p = '0;
            for (int b = 0; b < 8; b++) p = {p[6:0], rand_bit()};
            img_model[i] = p;
        end
        reset_test();
        load_display_test();
        origin_test();
        scale_test();
        undefined_test();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tests
common/disp_pkg.sv
common/img_mem_if.sv
src/cmd_ctrl.sv
image_mem/image_mem.sv
src/out_stream.sv
src/img_disp_top.sv
tests/tb_img_disp.sv
